// File: build.f
hw/feeder_pkg.sv
hw/test_cmd_decoder.sv
hw/stream_sender.sv
hw/pattern_engine.sv
hw/hdmi_test_feeder.sv
tb/tb_clock_gen.sv
tb/hdmi_test_feeder_tb.sv

// File: Makefile
# Verilator build and run for the hdmi test feeder testbench.
TOP := hdmi_test_feeder_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// File: audio_tone.hex
// one column: 16-bit two's complement sample, one sine period in 32 steps.
0000
0C7C
187E
238E
2D41
3537
3B21
3EC5
4000
3EC5
3B21
3537
2D41
238E
187E
0C7C
0000
F384
E782
DC72
D2BF
CAC9
C4DF
C13B
C000
C13B
C4DF
CAC9
D2BF
DC72
E782
F384

// File: tb/hdmi_test_feeder_tb.sv
// hdmi test feeder testbench.
// issues host commands over req/ack, models both sinks with random rdy,
// and checks every accepted beat against a reference pattern model.
`timescale 1ns/100ps
`default_nettype none

module hdmi_test_feeder_tb
   import feeder_pkg::*;
;

   logic        clk;
   logic        rst;
   logic        req;
   test_cmd_t   cmd;
   logic        ack;
   logic        video_rdy;
   logic        audio_rdy;
   logic [23:0] video_out;
   logic        video_valid;
   logic [15:0] audio_out;
   logic        audio_valid;

   logic [15:0] tone_ref [audio_depth]; // own copy of the tone table.
   logic [31:0] rnd;
   logic        bp_on;      // random back-pressure on both sinks.
   test_op_e    cur_op;     // command in flight.
   logic [23:0] cur_color;
   int          video_beats; // beats of the current command.
   int          audio_beats;
   int          beat_errors; // checker failures.
   int          seq_errors;  // handshake and count failures.
   int          err_base;
   int          total_video;
   int          total_audio;
   int          cycles;
   int          cycle_limit = (20 + 64 + 300 + 70 + 0 + 12 + 9) * 4 + 200;

   tb_clock_gen tb_clock_gen_i (.clk(clk), .rst(rst));

   hdmi_test_feeder hdmi_test_feeder_i (
      .clk(clk), .rst(rst), .req(req), .cmd(cmd), .ack(ack),
      .video_rdy(video_rdy), .audio_rdy(audio_rdy),
      .video_out(video_out), .video_valid(video_valid),
      .audio_out(audio_out), .audio_valid(audio_valid)
   );

   initial $readmemh("audio_tone.hex", tone_ref);

   // expected data for beat n of a command with the sample in the low 16 bits.
   function automatic logic [23:0] expected_beat(input test_op_e op,
                                                 input logic [23:0] color, input int beat);
      logic [7:0]          grey;
      logic [2:0]          bar;
      logic [audio_aw-1:0] taddr;
      grey  = beat[7:0];                       // ramp wraps at 256.
      bar   = 3'((beat / bar_width) % 8);
      taddr = audio_aw'(beat % audio_depth);
      case (op)
         op_solid: return color;
         op_bars:  return bar_colors[bar];
         op_ramp:  return {grey, grey, grey};
         default:  return {8'h00, tone_ref[taddr]};
      endcase
   endfunction

   // sink rdy driven 1 ns after the edge.
   initial begin : sink_ready
      integer seed;
      seed      = 32'h9c2d_d7c3;
      video_rdy = 1'b0;
      audio_rdy = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         rnd       = $random(seed);
         video_rdy = bp_on ? (rnd[1:0] != 2'b00) : 1'b1; // about 3 in 4.
         audio_rdy = bp_on ? (rnd[3:2] != 2'b00) : 1'b1;
      end
   end

   // beat checker sampling at the rising edge.
   always @(posedge clk) begin : beat_checker
      logic        want;
      logic [23:0] want_data;
      logic        req_q;
      logic        v_stall;
      logic        a_stall;
      logic [23:0] v_held;
      logic [15:0] a_held;
      if (rst) begin
         req_q       = 1'b0;
         v_stall     = 1'b0;
         a_stall     = 1'b0;
         video_beats = 0;
         audio_beats = 0;
         beat_errors = 0;
      end else begin
         if (req && !req_q) begin // a new command restarts the beat numbers.
            video_beats = 0;
            audio_beats = 0;
         end
         req_q = req;
         if ((video_valid || audio_valid) && (!req || ack)) begin
            beat_errors++;
            $display("%0t: valid raised outside an active command", $time);
         end
         want = (cur_op == op_audio) ? video_valid : audio_valid; // wrong stream.
         if (want) begin
            beat_errors++;
            $display("%0t: valid raised on the stream not selected by the opcode", $time);
         end
         if (v_stall) begin // data must hold while rdy is low.
            if (!video_valid) begin
               beat_errors++;
               $display("%0t: video_valid dropped before rdy", $time);
            end else if (video_out !== v_held) begin
               beat_errors++;
               $display("MISMATCH %0t video_out held %h got %h", $time, v_held, video_out);
            end
         end
         if (a_stall) begin
            if (!audio_valid) begin
               beat_errors++;
               $display("%0t: audio_valid dropped before rdy", $time);
            end else if (audio_out !== a_held) begin
               beat_errors++;
               $display("MISMATCH %0t audio_out held %h got %h", $time, a_held, audio_out);
            end
         end
         v_stall = video_valid && !video_rdy;
         a_stall = audio_valid && !audio_rdy;
         v_held  = video_out;
         a_held  = audio_out;
         if (video_valid && video_rdy) begin
            want_data = expected_beat(cur_op, cur_color, video_beats);
            if (video_out !== want_data) begin
               beat_errors++;
               $display("MISMATCH %0t video_out beat %0d expected %h got %h",
                        $time, video_beats, want_data, video_out);
            end
            video_beats++;
         end
         if (audio_valid && audio_rdy) begin
            want_data = expected_beat(cur_op, cur_color, audio_beats);
            if (audio_out !== want_data[15:0]) begin
               beat_errors++;
               $display("MISMATCH %0t audio_out beat %0d expected %h got %h",
                        $time, audio_beats, want_data[15:0], audio_out);
            end
            audio_beats++;
         end
      end
   end

   // run-length guard.
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: ack never completed");
         $display("Result: FAILED");
         $finish;
      end
   end

   // one full four-phase command returning the cycles from req to ack.
   task automatic run_cmd(input test_op_e op, input logic [23:0] color, input int count,
                          output int wait_cycles);
      int want_v;
      int want_a;
      cur_op    = op;
      cur_color = color;
      cmd.op    = op;
      cmd.color = color;
      cmd.count = beat_w'(count);
      req       = 1'b1;
      wait_cycles = 0;
      do begin
         @(posedge clk);
         #1;
         wait_cycles++;
      end while (!ack);
      want_v = (op == op_audio) ? 0 : count; // all beats before ack.
      want_a = (op == op_audio) ? count : 0;
      if (video_beats != want_v) begin
         seq_errors++;
         $display("MISMATCH %0t video beat count expected %0d got %0d",
                  $time, want_v, video_beats);
      end
      if (audio_beats != want_a) begin
         seq_errors++;
         $display("MISMATCH %0t audio beat count expected %0d got %0d",
                  $time, want_a, audio_beats);
      end
      total_video += video_beats;
      total_audio += audio_beats;
      req = 1'b0;
      @(posedge clk);
      #1;
      if (ack) begin // one cycle after req seen low.
         seq_errors++;
         $display("%0t: ack still high one cycle after req dropped", $time);
      end
   endtask

   task automatic report_test(input int n, input string name);
      $display("test %0d %s: %s", n, name,
               (beat_errors + seq_errors == err_base) ? "ok" : "errors");
      err_base = beat_errors + seq_errors;
   endtask

   initial begin : stimulus
      int wc;
      req         = 1'b0;
      cmd         = '0;
      bp_on       = 1'b0;
      cur_op      = op_solid;
      cur_color   = '0;
      seq_errors  = 0;
      err_base    = 0;
      cycles      = 0;
      total_video = 0;
      total_audio = 0;
      @(posedge clk);
      while (rst) @(posedge clk);
      #1;
      if (ack !== 1'b0 || video_valid !== 1'b0 || audio_valid !== 1'b0) begin
         seq_errors++;
         $display("%0t: ack or valid not low after reset", $time);
      end
      run_cmd(op_solid, 24'h12_80_EF, 20, wc);
      report_test(1, "solid colour");
      bp_on = 1'b1;
      run_cmd(op_bars, 24'h00_00_00, 64, wc);
      report_test(2, "colour bars");
      run_cmd(op_ramp, 24'h00_00_00, 300, wc);
      report_test(3, "grey ramp");
      run_cmd(op_audio, 24'h00_00_00, 70, wc);
      report_test(4, "audio tone");
      run_cmd(op_solid, 24'hAB_CD_EF, 0, wc);
      if (wc != 3) begin // req to start, start to done, done to ack.
         seq_errors++;
         $display("%0t: zero-count command acked after %0d cycles, not 3", $time, wc);
      end
      report_test(5, "handshake");
      run_cmd(op_bars, 24'h00_00_00, 12, wc);
      run_cmd(op_audio, 24'h00_00_00, 9, wc);
      report_test(6, "back to back");
      $display("summary: 6 tests, %0d beat errors, %0d sequence errors, %0d video, %0d audio",
               beat_errors, seq_errors, total_video, total_audio);
      if (beat_errors + seq_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// testbench clock and reset.
// 8 ns clock, reset held for the first two rising edges.
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period.
   end

   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0; // released with the other inputs.
   end

endmodule

`default_nettype wire

// File: hw/hdmi_test_feeder.sv
// hdmi test feeder top level.
// decoder takes host commands, sender sequences beats, engine forms
// the pixel and sample data. no added pipeline stages.
`timescale 1ns/100ps
`default_nettype none

module hdmi_test_feeder
   import feeder_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      req,
   input  wire test_cmd_t cmd,
   output      logic      ack,
   input  wire logic      video_rdy,
   input  wire logic      audio_rdy,
   output      logic [23:0] video_out,
   output      logic        video_valid,
   output      logic [15:0] audio_out,
   output      logic        audio_valid
);

   logic              start;  // decoder to sender.
   logic              done;   // sender to decoder.
   job_t              job;    // latched command.
   logic [beat_w-1:0] index;  // current beat.

   test_cmd_decoder test_cmd_decoder_i (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .cmd   (cmd),
      .ack   (ack),
      .start (start),
      .job   (job),
      .done  (done)
   );

   stream_sender stream_sender_i (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .job         (job),
      .index       (index),
      .video_valid (video_valid),
      .audio_valid (audio_valid),
      .video_rdy   (video_rdy),
      .audio_rdy   (audio_rdy),
      .done        (done)
   );

   pattern_engine pattern_engine_i (
      .index     (index),
      .job       (job),
      .video_out (video_out),
      .audio_out (audio_out)
   );

endmodule

`default_nettype wire

// File: hw/pattern_engine.sv
// pattern engine.
// forms the pixel or audio sample for the current beat from the job
// opcode and the beat index. purely combinational apart from the
// tone table, which is loaded once from a hex file.
`timescale 1ns/100ps
`default_nettype none

module pattern_engine
   import feeder_pkg::*;
(
   input  wire logic [beat_w-1:0] index,
   input  wire job_t              job,
   output      logic [23:0]       video_out,
   output      logic [15:0]       audio_out
);

   logic [15:0]         tone_mem [audio_depth]; // one tone period.
   logic [2:0]          bar_sel;  // bar number modulo 8.
   logic [audio_aw-1:0] tone_addr; // index modulo audio_depth.
   logic [beat_w-1:0]   bar_num;

   initial $readmemh("audio_tone.hex", tone_mem);

   assign bar_num   = index / beat_w'(bar_width);
   assign bar_sel   = bar_num[2:0];
   assign tone_addr = index[audio_aw-1:0];

   // pixel select.
   always_comb begin
      video_out = 24'h00_00_00; // zero unless a video op.
      case (job.op)
         op_solid: video_out = job.color;
         op_bars:  video_out = bar_colors[bar_sel];
         op_ramp:  video_out = {3{index[7:0]}}; // grey, wraps at 256.
         default:  video_out = 24'h00_00_00;
      endcase
   end

   // sample select.
   always_comb begin
      audio_out = 16'h0000;
      if (job.op == op_audio) begin
         audio_out = tone_mem[tone_addr];
      end
   end

endmodule

`default_nettype wire

// File: hw/stream_sender.sv
// stream sender.
// sequences job.count beats over valid/rdy to the video or audio sink,
// steps the beat index on every accepted beat and pulses done at the end.
`timescale 1ns/100ps
`default_nettype none

module stream_sender
   import feeder_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              start,
   input  wire job_t              job,
   output      logic [beat_w-1:0] index,
   output      logic              video_valid,
   output      logic              audio_valid,
   input  wire logic              video_rdy,
   input  wire logic              audio_rdy,
   output      logic              done
);

   typedef enum logic {
      st_wait, // idle between jobs.
      st_send  // valid raised on the selected stream.
   } send_state_e;

   send_state_e state;
   logic        sel_rdy;   // rdy of the selected stream.
   logic        xfer;      // beat accepted this cycle.
   logic        last_beat; // index is on the final beat.

   // valid only while sending, and only on one stream.
   always_comb begin
      video_valid = 1'b0;
      audio_valid = 1'b0;
      if (state == st_send) begin
         if (job.to_audio) audio_valid = 1'b1;
         else              video_valid = 1'b1;
      end
   end

   assign sel_rdy   = job.to_audio ? audio_rdy : video_rdy; // other rdy ignored.
   assign xfer      = (state == st_send) && sel_rdy;
   assign last_beat = (index == job.count - beat_w'(1));

   // state, index and done.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_wait;
         index <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            st_wait: begin
               if (start) begin
                  index <= '0;
                  if (job.count == '0) done  <= 1'b1; // nothing to send.
                  else                 state <= st_send;
               end
            end
            st_send: begin
               if (xfer) begin // hold everything under back-pressure.
                  index <= index + beat_w'(1);
                  if (last_beat) begin
                     state <= st_wait;
                     done  <= 1'b1;
                  end
               end
            end
            default: state <= st_wait;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/test_cmd_decoder.sv
// test command decoder.
// runs the host four-phase req/ack handshake, latches one command into a
// job and starts the sender. ack is held from the end of the stream
// until req falls.
`timescale 1ns/100ps
`default_nettype none

module test_cmd_decoder
   import feeder_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      req,
   input  wire test_cmd_t cmd,
   output      logic      ack,
   output      logic      start,
   output      job_t      job,
   input  wire logic      done
);

   typedef enum logic [1:0] {
      st_idle,     // waiting for req.
      st_busy,     // job streaming.
      st_complete  // ack high, waiting for req low.
   } dec_state_e;

   dec_state_e state;

   // handshake fsm, ack and start are registered.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_idle;
         ack   <= 1'b0;
         start <= 1'b0;
      end else begin
         start <= 1'b0; // one-cycle pulse.
         case (state)
            st_idle: begin
               if (req && !ack) begin
                  start <= 1'b1;
                  state <= st_busy;
               end
            end
            st_busy: begin
               if (done) begin // last beat accepted.
                  ack   <= 1'b1;
                  state <= st_complete;
               end
            end
            st_complete: begin
               if (!req) begin // host released req.
                  ack   <= 1'b0;
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // job payload, loaded on accept only.
   always_ff @(posedge clk) begin
      if (state == st_idle && req && !ack) begin
         job.op       <= cmd.op;
         job.color    <= cmd.color;
         job.count    <= cmd.count;
         job.to_audio <= (cmd.op == op_audio); // audio goes to its own sink.
      end
   end

endmodule

`default_nettype wire

// File: hw/feeder_pkg.sv
// hdmi test feeder shared definitions.
// opcodes, host command and decoded job structs, and the colour-bar table
// used by the pattern engine and the testbench.
`default_nettype none

package feeder_pkg;

   localparam int beat_w      = 16; // beat count and beat index width.
   localparam int audio_depth = 32; // samples in one tone period.
   localparam int audio_aw    = 5;  // tone memory address width.
   localparam int bar_width   = 8;  // beats per colour bar.

   // test pattern opcodes.
   typedef enum logic [1:0] {
      op_solid = 2'd0, // one colour for every beat.
      op_bars  = 2'd1, // eight vertical bars.
      op_ramp  = 2'd2, // grey ramp, wraps at 256.
      op_audio = 2'd3  // tone samples to the audio sink.
   } test_op_e;

   // host command, 42 bits.
   typedef struct packed {
      test_op_e          op;
      logic [23:0]       color; // rgb, op_solid only.
      logic [beat_w-1:0] count; // beats to stream.
   } test_cmd_t;

   // decoded job, 43 bits.
   typedef struct packed {
      test_op_e          op;
      logic [23:0]       color;
      logic [beat_w-1:0] count;
      logic              to_audio; // set for op_audio.
   } job_t;

   // bar colours, left to right.
   localparam logic [0:7][23:0] bar_colors = {
      24'hFF_FF_FF, // white.
      24'hFF_FF_00, // yellow.
      24'h00_FF_FF, // cyan.
      24'h00_FF_00, // green.
      24'hFF_00_FF, // magenta.
      24'hFF_00_00, // red.
      24'h00_00_FF, // blue.
      24'h00_00_00  // black.
   };

endpackage

`default_nettype wire
